// File: flist.f
src/core_pkg.sv
src/core_decoder.sv
src/core_regfile.sv
src/core_alu.sv
src/core_top.sv
src/instr_tracer.sv
src/core_top_tracing.sv
test/tb_checker.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the tracing core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_top -o sim_tb_top
./obj_dir/sim_tb_top | tee sim.log

if grep -q "^Test OK$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: src/core_alu.sv
////////////////////////////////////////
// ALU for the supported RV32I subset
////////////////////////////////////////

`timescale 1ns/10ps

module core_alu (
  input  core_pkg::alu_op_e         op_i,
  input  logic [core_pkg::XLEN-1:0] a_i,
  input  logic [core_pkg::XLEN-1:0] b_i,
  output logic [core_pkg::XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt;

  assign shamt = b_i[4:0];
  assign lt    = $signed(a_i) < $signed(b_i);

  always_comb begin
    unique case (op_i)
      core_pkg::ALU_ADD:    result_o = a_i + b_i;
      core_pkg::ALU_SUB:    result_o = a_i - b_i;
      core_pkg::ALU_AND:    result_o = a_i & b_i;
      core_pkg::ALU_OR:     result_o = a_i | b_i;
      core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      core_pkg::ALU_SLL:    result_o = a_i << shamt;
      core_pkg::ALU_SRL:    result_o = a_i >> shamt;
      core_pkg::ALU_SLT:    result_o = {{(core_pkg::XLEN-1){1'b0}}, lt};
      core_pkg::ALU_PASS_B: result_o = b_i;
      default:              result_o = '0;
    endcase
  end

endmodule

// File: src/core_decoder.sv
////////////////////////////////////////
// Instruction decoder
// Picks ALU operation, operands and immediate
////////////////////////////////////////

`timescale 1ns/10ps

module core_decoder (
  input  logic [31:0]      instr_i,
  output core_pkg::decode_t dec_o
);

  core_pkg::opcode_e opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;

  assign opcode = core_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    dec_o          = '0;
    dec_o.alu_op   = core_pkg::ALU_ADD;
    dec_o.rs1_addr = instr_i[19:15];
    dec_o.rs2_addr = instr_i[24:20];
    dec_o.rd_addr  = instr_i[11:7];
    dec_o.rf_we    = 1'b1;

    unique case (opcode)
      core_pkg::OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          unique case (funct3)
            3'b000:  dec_o.alu_op = core_pkg::ALU_ADD;
            3'b001:  dec_o.alu_op = core_pkg::ALU_SLL;
            3'b010:  dec_o.alu_op = core_pkg::ALU_SLT;
            3'b100:  dec_o.alu_op = core_pkg::ALU_XOR;
            3'b101:  dec_o.alu_op = core_pkg::ALU_SRL;
            3'b110:  dec_o.alu_op = core_pkg::ALU_OR;
            3'b111:  dec_o.alu_op = core_pkg::ALU_AND;
            default: dec_o.illegal = 1'b1;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec_o.alu_op = core_pkg::ALU_SUB;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end
      core_pkg::OPC_OP_IMM: begin
        dec_o.use_imm  = 1'b1;
        dec_o.rs2_addr = '0;
        dec_o.imm      = {{20{instr_i[31]}}, instr_i[31:20]};
        unique case (funct3)
          3'b000:  dec_o.alu_op = core_pkg::ALU_ADD;
          3'b100:  dec_o.alu_op = core_pkg::ALU_XOR;
          3'b110:  dec_o.alu_op = core_pkg::ALU_OR;
          3'b111:  dec_o.alu_op = core_pkg::ALU_AND;
          // SLTI, SLTIU and immediate shifts are not supported
          default: dec_o.illegal = 1'b1;
        endcase
      end
      core_pkg::OPC_LUI: begin
        dec_o.alu_op   = core_pkg::ALU_PASS_B;
        dec_o.use_imm  = 1'b1;
        dec_o.rs1_addr = '0;
        dec_o.rs2_addr = '0;
        dec_o.imm      = {instr_i[31:12], 12'b0};
      end
      default: dec_o.illegal = 1'b1;
    endcase

    if (dec_o.illegal) begin
      dec_o.rf_we = 1'b0;
    end
  end

endmodule

// File: src/core_pkg.sv
////////////////////////////////////////
// Core package
// Widths, opcode and ALU enums, decode, retirement and trace records
////////////////////////////////////////

package core_pkg;

  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_REGS = 32;
  localparam int unsigned REG_AW   = $clog2(NUM_REGS);
  localparam int unsigned DELTA_W  = 16;

  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0080;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef struct packed {
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   imm;
    logic              use_imm;
    logic              rf_we;
    logic              illegal;
  } decode_t;

  typedef struct packed {
    logic              valid;
    logic [63:0]       order;
    logic [31:0]       insn;
    logic              trap;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_rdata;
    logic [XLEN-1:0]   rs2_rdata;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_wdata;
    logic [XLEN-1:0]   pc_rdata;
    logic [XLEN-1:0]   pc_wdata;
  } retire_t;

  typedef struct packed {
    logic [63:0]       order;
    logic [XLEN-1:0]   pc;
    logic [31:0]       insn;
    logic              trap;
    logic [REG_AW-1:0] rd_addr;
    logic [XLEN-1:0]   rd_wdata;
    logic [DELTA_W-1:0] delta;
  } trace_pkt_t;

endpackage

// File: src/core_regfile.sv
////////////////////////////////////////
// Flip-flop register file
// Two read ports, one write port, x0 tied to zero
////////////////////////////////////////

`timescale 1ns/10ps

module core_regfile (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]   rdata_a_o,
  output logic [core_pkg::XLEN-1:0]   rdata_b_o,
  input  logic                        we_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i
);

  logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

  assign regs[0] = '0;

  for (genvar i = 1; i < core_pkg::NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        regs[i] <= '0;
      end else if (we_i && waddr_i == i) begin
        regs[i] <= wdata_i;
      end
    end
  end

  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

// File: src/core_top.sv
////////////////////////////////////////
// Execute core
// Runs one instruction per strobe and registers its retirement record
////////////////////////////////////////

`timescale 1ns/10ps

module core_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  logic [31:0]       instr_i,
  output core_pkg::retire_t retire_o
);

  core_pkg::decode_t         dec;
  core_pkg::retire_t         retire_d;
  core_pkg::retire_t         retire_q;
  logic                      retire_valid_q;

  logic [core_pkg::XLEN-1:0] pc_q;
  logic [63:0]               order_q;

  logic [core_pkg::XLEN-1:0] rs1_rdata;
  logic [core_pkg::XLEN-1:0] rs2_rdata;
  logic [core_pkg::XLEN-1:0] alu_b;
  logic [core_pkg::XLEN-1:0] alu_result;
  logic                      rf_we;
  logic                      rd_written;

  core_decoder u_decoder (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  core_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec.rs1_addr),
    .raddr_b_i (dec.rs2_addr),
    .rdata_a_o (rs1_rdata),
    .rdata_b_o (rs2_rdata),
    .we_i      (rf_we),
    .waddr_i   (dec.rd_addr),
    .wdata_i   (alu_result)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_rdata;

  core_alu u_alu (
    .op_i     (dec.alu_op),
    .a_i      (rs1_rdata),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  assign rf_we      = instr_valid_i & dec.rf_we;
  // x0 writes are reported as no write
  assign rd_written = dec.rf_we && (dec.rd_addr != '0);

  always_comb begin
    retire_d           = '0;
    retire_d.order     = order_q;
    retire_d.insn      = instr_i;
    retire_d.trap      = dec.illegal;
    retire_d.rs1_addr  = dec.rs1_addr;
    retire_d.rs2_addr  = dec.rs2_addr;
    retire_d.rs1_rdata = rs1_rdata;
    retire_d.rs2_rdata = rs2_rdata;
    retire_d.rd_addr   = rd_written ? dec.rd_addr : '0;
    retire_d.rd_wdata  = rd_written ? alu_result : '0;
    retire_d.pc_rdata  = pc_q;
    retire_d.pc_wdata  = pc_q + 32'd4;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q           <= core_pkg::BOOT_PC;
      order_q        <= '0;
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= instr_valid_i;
      if (instr_valid_i) begin
        pc_q    <= pc_q + 32'd4;
        order_q <= order_q + 64'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      retire_q <= retire_d;
    end
  end

  always_comb begin
    retire_o       = retire_q;
    retire_o.valid = retire_valid_q;
  end

endmodule

// File: src/core_top_tracing.sv
////////////////////////////////////////
// Core with tracer attached
////////////////////////////////////////

`timescale 1ns/10ps

module core_top_tracing (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [core_pkg::XLEN-1:0] hart_id_i,
  input  logic                      instr_valid_i,
  input  logic [31:0]               instr_i,
  output core_pkg::retire_t         retire_o,
  output logic                      trace_valid_o,
  output core_pkg::trace_pkt_t      trace_pkt_o,
  output logic [core_pkg::XLEN-1:0] trace_hart_o
);

  core_top u_core_top (
    .clk_i,
    .rst_n_i,
    .instr_valid_i,
    .instr_i,
    .retire_o
  );

  // Tracer watches the retirement record
  instr_tracer u_instr_tracer (
    .clk_i,
    .rst_n_i,
    .hart_id_i,
    .retire_i (retire_o),
    .trace_valid_o,
    .trace_pkt_o,
    .trace_hart_o
  );

endmodule

// File: src/instr_tracer.sv
////////////////////////////////////////
// Instruction tracer
// Packs retirements with cycle deltas
////////////////////////////////////////

`timescale 1ns/10ps

module instr_tracer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [core_pkg::XLEN-1:0] hart_id_i,
  input  core_pkg::retire_t         retire_i,
  output logic                      trace_valid_o,
  output core_pkg::trace_pkt_t      trace_pkt_o,
  output logic [core_pkg::XLEN-1:0] trace_hart_o
);

  logic [core_pkg::XLEN-1:0]    cycle_q;
  logic [core_pkg::XLEN-1:0]    last_q;
  logic                         seen_q;
  logic [core_pkg::XLEN-1:0]    elapsed;
  logic [core_pkg::DELTA_W-1:0] delta;

  assign elapsed = cycle_q - last_q;

  always_comb begin
    if (!seen_q) begin
      delta = '0;
    end else if (|elapsed[core_pkg::XLEN-1:core_pkg::DELTA_W]) begin
      delta = '1;
    end else begin
      delta = elapsed[core_pkg::DELTA_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cycle_q       <= '0;
      last_q        <= '0;
      seen_q        <= 1'b0;
      trace_valid_o <= 1'b0;
    end else begin
      cycle_q       <= cycle_q + 1'b1;
      trace_valid_o <= retire_i.valid;
      if (retire_i.valid) begin
        last_q <= cycle_q;
        seen_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_i.valid) begin
      trace_pkt_o.order    <= retire_i.order;
      trace_pkt_o.pc       <= retire_i.pc_rdata;
      trace_pkt_o.insn     <= retire_i.insn;
      trace_pkt_o.trap     <= retire_i.trap;
      trace_pkt_o.rd_addr  <= retire_i.rd_addr;
      trace_pkt_o.rd_wdata <= retire_i.rd_wdata;
      trace_pkt_o.delta    <= delta;
      trace_hart_o         <= hart_id_i;
    end
  end

endmodule

// File: test/tb_checker.sv
////////////////////////////////////////
// Trace checker
// Compares retirement records and trace packets with expected results
////////////////////////////////////////

`timescale 1ns/10ps

module tb_checker (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         instr_valid_i,
  input  logic [31:0]                  instr_i,
  input  logic [core_pkg::XLEN-1:0]    hart_id_i,
  input  logic                         exp_trap_i,
  input  logic [4:0]                   exp_rd_i,
  input  logic [31:0]                  exp_data_i,
  input  logic [core_pkg::DELTA_W-1:0] exp_delta_i,
  input  core_pkg::retire_t            retire_i,
  input  logic                         trace_valid_i,
  input  core_pkg::trace_pkt_t         trace_pkt_i,
  input  logic [core_pkg::XLEN-1:0]    trace_hart_i,
  input  logic                         done_i,
  output int unsigned                  pkt_count_o,
  output int unsigned                  err_count_o
);

  typedef struct packed {
    logic [31:0]                  insn;
    logic                         trap;
    logic [4:0]                   rd;
    logic [31:0]                  data;
    logic [core_pkg::DELTA_W-1:0] delta;
    logic [31:0]                  cyc;
    logic                         ret_seen;
    logic [7:0]                   ret_bad;
  } expect_t;

  expect_t     pending [$];
  expect_t     incoming;
  logic [31:0] shadow [32] = '{default: '0};
  logic [31:0] cyc      = '0;
  int unsigned packets  = 0;
  int unsigned retired  = 0;
  int unsigned passed   = 0;
  int unsigned errors   = 0;
  int unsigned row_bad  = 0;
  bit          reported = 1'b0;

  assign pkt_count_o = packets;
  assign err_count_o = errors;

  task automatic compare_field(input int unsigned idx, input string name,
                               input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t: row %0d %s is %0h, expected %0h",
               $time, idx, name, got, want);
      row_bad++;
    end
  endtask

  task automatic check_retire();
    expect_t     cur;
    int unsigned pos;
    logic [31:0] exp_pc;
    pos     = retired - packets;
    cur     = pending[pos];
    row_bad = 0;
    exp_pc  = core_pkg::BOOT_PC + 32'(retired) * 32'd4;
    compare_field(retired, "retire order", retire_i.order, 64'(retired));
    compare_field(retired, "retire pc", 64'(retire_i.pc_rdata), 64'(exp_pc));
    compare_field(retired, "retire next pc", 64'(retire_i.pc_wdata), 64'(exp_pc + 32'd4));
    compare_field(retired, "retire insn", 64'(retire_i.insn), 64'(cur.insn));
    compare_field(retired, "retire trap", 64'(retire_i.trap), 64'(cur.trap));
    compare_field(retired, "retire rd", 64'(retire_i.rd_addr), 64'(cur.rd));
    compare_field(retired, "retire rd data", 64'(retire_i.rd_wdata), 64'(cur.data));
    // Source data is the register state before this instruction
    compare_field(retired, "retire rs1 data", 64'(retire_i.rs1_rdata),
                  64'(shadow[retire_i.rs1_addr]));
    compare_field(retired, "retire rs2 data", 64'(retire_i.rs2_rdata),
                  64'(shadow[retire_i.rs2_addr]));
    compare_field(retired, "retire latency", 64'(cyc - cur.cyc), 64'd1);
    shadow[cur.rd] = cur.data;
    cur.ret_seen   = 1'b1;
    cur.ret_bad    = 8'(row_bad);
    pending[pos]   = cur;
    retired++;
  endtask

  task automatic check_packet();
    expect_t     cur;
    logic [31:0] exp_pc;
    cur     = pending.pop_front();
    row_bad = 0;
    if (!cur.ret_seen) begin
      $display("Trace packet %0d arrived without a retirement record", packets);
      row_bad++;
    end else begin
      row_bad = cur.ret_bad;
    end
    // PC steps by 4 per retirement, traps included
    exp_pc  = core_pkg::BOOT_PC + 32'(packets) * 32'd4;
    compare_field(packets, "order", trace_pkt_i.order, 64'(packets));
    compare_field(packets, "pc", 64'(trace_pkt_i.pc), 64'(exp_pc));
    compare_field(packets, "insn", 64'(trace_pkt_i.insn), 64'(cur.insn));
    compare_field(packets, "trap", 64'(trace_pkt_i.trap), 64'(cur.trap));
    compare_field(packets, "rd", 64'(trace_pkt_i.rd_addr), 64'(cur.rd));
    compare_field(packets, "rd data", 64'(trace_pkt_i.rd_wdata), 64'(cur.data));
    compare_field(packets, "delta", 64'(trace_pkt_i.delta), 64'(cur.delta));
    compare_field(packets, "hart", 64'(trace_hart_i), 64'(hart_id_i));
    compare_field(packets, "latency", 64'(cyc - cur.cyc), 64'd2);
    errors += row_bad;
    if (row_bad == 0) begin
      passed++;
    end
    $display("test %0d insn %08h: %s", packets, cur.insn, (row_bad == 0) ? "pass" : "fail");
    packets++;
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (trace_valid_i) begin
        if (pending.size() == 0) begin
          $display("Unexpected trace packet at %0t with no instruction pending", $time);
          errors++;
        end else begin
          check_packet();
        end
      end
      if (retire_i.valid) begin
        if (retired < packets || retired >= packets + pending.size()) begin
          $display("Unexpected retirement record at %0t with no instruction pending", $time);
          errors++;
        end else begin
          check_retire();
        end
      end
      if (instr_valid_i) begin
        incoming.insn     = instr_i;
        incoming.trap     = exp_trap_i;
        incoming.rd       = exp_rd_i;
        incoming.data     = exp_data_i;
        incoming.delta    = exp_delta_i;
        incoming.cyc      = cyc;
        incoming.ret_seen = 1'b0;
        incoming.ret_bad  = '0;
        pending.push_back(incoming);
      end
      cyc++;
    end
    if (done_i && !reported) begin
      reported = 1'b1;
      if (pending.size() != 0) begin
        $display("%0d instructions never produced a trace packet", pending.size());
        errors += pending.size();
      end
      $display("%0d tests: %0d passed, %0d failed, %0d errors",
               packets, passed, packets - passed, errors);
    end
  end

endmodule

// File: test/tb_top.sv
////////////////////////////////////////
// Testbench for the tracing core
// Drives the instruction table, runs the watchdog
////////////////////////////////////////

`timescale 1ns/10ps

module tb_top;

  localparam int unsigned NUM_ROWS  = 23;
  localparam int          RAND_GAP  = -1;
  localparam int unsigned DELTA_MAX = (1 << core_pkg::DELTA_W) - 1;
  localparam logic [31:0] SEED      = 32'hd301abe5;

  logic                         clk;
  logic                         rst_n;
  logic                         instr_valid;
  logic [31:0]                  instr;
  logic [core_pkg::XLEN-1:0]    hart_id;
  core_pkg::retire_t            retire;
  logic                         trace_valid;
  core_pkg::trace_pkt_t         trace_pkt;
  logic [core_pkg::XLEN-1:0]    trace_hart;

  logic                         exp_trap;
  logic [4:0]                   exp_rd;
  logic [31:0]                  exp_data;
  logic [core_pkg::DELTA_W-1:0] exp_delta;
  logic                         done;
  int unsigned                  pkt_count;
  int unsigned                  err_count;

  logic [31:0] row_instr [NUM_ROWS];
  int          row_gap   [NUM_ROWS];
  logic        row_trap  [NUM_ROWS];
  logic [4:0]  row_rd    [NUM_ROWS];
  logic [31:0] row_data  [NUM_ROWS];
  int unsigned n_rows = 0;
  int unsigned limit;
  bit          table_ready = 1'b0;

  core_top_tracing i_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .hart_id_i     (hart_id),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .retire_o      (retire),
    .trace_valid_o (trace_valid),
    .trace_pkt_o   (trace_pkt),
    .trace_hart_o  (trace_hart)
  );

  tb_checker i_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .hart_id_i     (hart_id),
    .exp_trap_i    (exp_trap),
    .exp_rd_i      (exp_rd),
    .exp_data_i    (exp_data),
    .exp_delta_i   (exp_delta),
    .retire_i      (retire),
    .trace_valid_i (trace_valid),
    .trace_pkt_i   (trace_pkt),
    .trace_hart_i  (trace_hart),
    .done_i        (done),
    .pkt_count_o   (pkt_count),
    .err_count_o   (err_count)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] encode_itype(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encode_rtype(logic [6:0] f7, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3,
                                               logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_utype(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_row(input logic [31:0] row_insn, input int gap, input logic trap,
                         input logic [4:0] rd, input logic [31:0] data);
    row_instr[n_rows] = row_insn;
    row_gap[n_rows]   = gap;
    row_trap[n_rows]  = trap;
    row_rd[n_rows]    = rd;
    row_data[n_rows]  = data;
    n_rows++;
  endtask

  task automatic build_table();
    int unsigned gap_sum;
    gap_sum = 0;
    // Immediate forms
    add_row(encode_itype(12'h123, 5'd0, 3'b000, 5'd1), 0, 1'b0, 5'd1, 32'h0000_0123);
    add_row(encode_itype(12'hffb, 5'd0, 3'b000, 5'd2), 0, 1'b0, 5'd2, 32'hffff_fffb);
    add_row(encode_itype(12'h0f0, 5'd1, 3'b111, 5'd3), 1, 1'b0, 5'd3, 32'h0000_0020);
    add_row(encode_itype(12'h700, 5'd1, 3'b110, 5'd4), 0, 1'b0, 5'd4, 32'h0000_0723);
    add_row(encode_itype(12'h7ff, 5'd2, 3'b100, 5'd5), 0, 1'b0, 5'd5, 32'hffff_f804);
    add_row(encode_utype(20'habcde, 5'd6), RAND_GAP, 1'b0, 5'd6, 32'habcd_e000);
    // Register forms reading earlier results
    add_row(encode_rtype(7'h00, 5'd1, 5'd6, 3'b000, 5'd7), 0, 1'b0, 5'd7, 32'habcd_e123);
    add_row(encode_rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd8), 0, 1'b0, 5'd8, 32'h0000_0128);
    add_row(encode_rtype(7'h00, 5'd2, 5'd6, 3'b111, 5'd9), 2, 1'b0, 5'd9, 32'habcd_e000);
    add_row(encode_rtype(7'h00, 5'd6, 5'd3, 3'b110, 5'd10), 0, 1'b0, 5'd10, 32'habcd_e020);
    add_row(encode_rtype(7'h00, 5'd6, 5'd7, 3'b100, 5'd11), 0, 1'b0, 5'd11, 32'h0000_0123);
    add_row(encode_rtype(7'h00, 5'd8, 5'd1, 3'b001, 5'd12), RAND_GAP, 1'b0, 5'd12, 32'h0001_2300);
    add_row(encode_rtype(7'h00, 5'd5, 5'd6, 3'b101, 5'd13), 0, 1'b0, 5'd13, 32'h0abc_de00);
    add_row(encode_rtype(7'h00, 5'd1, 5'd2, 3'b010, 5'd14), 0, 1'b0, 5'd14, 32'h0000_0001);
    add_row(encode_rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd15), 0, 1'b0, 5'd15, 32'h0000_0000);
    // Traps, then x1 must still hold its value
    add_row(32'hffff_ffff, 1, 1'b1, 5'd0, 32'h0);
    add_row(encode_itype(12'h005, 5'd1, 3'b010, 5'd1), 0, 1'b1, 5'd0, 32'h0);
    add_row(encode_itype(12'h000, 5'd1, 3'b000, 5'd17), 0, 1'b0, 5'd17, 32'h0000_0123);
    // x0 stays zero
    add_row(encode_itype(12'h007, 5'd1, 3'b000, 5'd0), 0, 1'b0, 5'd0, 32'h0);
    add_row(encode_rtype(7'h00, 5'd1, 5'd0, 3'b000, 5'd18), 0, 1'b0, 5'd18, 32'h0000_0123);
    // Long idle gap saturates the delta
    add_row(encode_itype(12'h001, 5'd18, 3'b000, 5'd19), 70000, 1'b0, 5'd19, 32'h0000_0124);
    add_row(encode_rtype(7'h20, 5'd1, 5'd1, 3'b001, 5'd21), RAND_GAP, 1'b1, 5'd0, 32'h0);
    add_row(encode_rtype(7'h00, 5'd17, 5'd19, 3'b100, 5'd20), 0, 1'b0, 5'd20, 32'h0000_0007);
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (row_gap[i] == RAND_GAP) begin
        row_gap[i] = int'($urandom % 32'd8);
      end
      gap_sum += row_gap[i];
    end
    limit = 5 + gap_sum + 2 * NUM_ROWS + 50;
  endtask

  initial begin
    int unsigned step;
    void'($urandom(SEED));
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    hart_id     = 32'h0000_0005;
    exp_trap    = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    exp_delta   = '0;
    done        = 1'b0;
    build_table();
    table_ready = 1'b1;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      instr_valid = 1'b0;
      repeat (row_gap[i]) @(negedge clk);
      step        = row_gap[i] + 1;
      instr_valid = 1'b1;
      instr       = row_instr[i];
      exp_trap    = row_trap[i];
      exp_rd      = row_rd[i];
      exp_data    = row_data[i];
      if (i == 0) begin
        exp_delta = '0;
      end else if (step > DELTA_MAX) begin
        exp_delta = '1;
      end else begin
        exp_delta = step[core_pkg::DELTA_W-1:0];
      end
      @(negedge clk);
    end
    instr_valid = 1'b0;

    wait (pkt_count == NUM_ROWS);
    // Idle a little so a stray extra packet would still be seen
    repeat (4) @(negedge clk);
    done = 1'b1;
    @(negedge clk);
    if (err_count == 0 && pkt_count == NUM_ROWS) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (limit) @(posedge clk);
    $display("Timeout: only %0d of %0d trace packets after %0d cycles",
             pkt_count, NUM_ROWS, limit);
    $display("Test FAILED");
    $finish;
  end

endmodule
